// File: hw/mips_pkg.sv
package mips_pkg;

    typedef enum logic [5:0] {
        OP_SPECIAL = 6'h00, OP_REGIMM = 6'h01, OP_J     = 6'h02, OP_JAL   = 6'h03,
        OP_BEQ     = 6'h04, OP_BNE    = 6'h05, OP_BLEZ  = 6'h06, OP_BGTZ  = 6'h07,
        OP_ADDI    = 6'h08, OP_ADDIU  = 6'h09, OP_SLTI  = 6'h0a, OP_SLTIU = 6'h0b,
        OP_ANDI    = 6'h0c, OP_ORI    = 6'h0d, OP_XORI  = 6'h0e, OP_LUI   = 6'h0f,
        OP_LB      = 6'h20, OP_LH     = 6'h21, OP_LW    = 6'h23, OP_LBU   = 6'h24,
        OP_LHU     = 6'h25, OP_SW     = 6'h2b
    } opcode_e;

    typedef enum logic [5:0] {
        F_SLL  = 6'h00, F_SRL  = 6'h02, F_SRA  = 6'h03, F_SLLV  = 6'h04, F_SRLV = 6'h06,
        F_SRAV = 6'h07, F_JR   = 6'h08, F_JALR = 6'h09, F_BREAK = 6'h0d, F_ADD  = 6'h20,
        F_ADDU = 6'h21, F_SUB  = 6'h22, F_SUBU = 6'h23, F_AND   = 6'h24, F_OR   = 6'h25,
        F_XOR  = 6'h26, F_NOR  = 6'h27, F_SLT  = 6'h2a, F_SLTU  = 6'h2b
    } funct_e;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_SLT, ALU_SLTU, ALU_SLL, ALU_SRL,
        ALU_SRA, ALU_LUI, ALU_OR, ALU_XOR, ALU_AND, ALU_NOR
    } alu_op_e;

    typedef enum logic [1:0] {PC_NEXT, PC_BRANCH, PC_JUMP, PC_REG} pc_sel_e;
    typedef enum logic [1:0] {A_RS, A_PC, A_SHAMT} alu_a_e;
    typedef enum logic [1:0] {B_RT, B_IMM, B_EIGHT} alu_b_e;
    typedef enum logic [1:0] {W_RD, W_RT, W_R31} wsel_e;
    typedef enum logic [1:0] {SZ_BYTE, SZ_HALF, SZ_WORD} mem_size_e;

    typedef struct packed {
        logic        valid;
        logic        we;
        logic [29:0] addr;  // Word address.
        logic [31:0] wdata;
        logic [3:0]  be;
    } mem_req_t;

    typedef struct packed {
        alu_op_e   alu_op;
        alu_a_e    alu_a;
        alu_b_e    alu_b;
        logic      imm_sext;
        logic      reg_write;
        wsel_e     waddr_sel;
        logic      is_load;
        logic      is_store;
        mem_size_e mem_size;
        logic      load_signed;
        logic      halt;
    } ctrl_t;

    typedef struct packed {
        logic [31:0] pc;
        logic        wen;
        logic [4:0]  waddr;
        logic [31:0] wdata;
    } retire_t;

endpackage

// File: hw/alu.sv
`timescale 1ns/1ps
module alu (
    input  mips_pkg::alu_op_e op,
    input  logic [31:0]       a,
    input  logic [31:0]       b,
    output logic [31:0]       y
);
    always_comb begin
        case (op)
            mips_pkg::ALU_ADD:  y = a + b;
            mips_pkg::ALU_SUB:  y = a - b;
            mips_pkg::ALU_SLT:  y = {31'd0, $signed(a) < $signed(b)};
            mips_pkg::ALU_SLTU: y = {31'd0, a < b};
            mips_pkg::ALU_SLL:  y = b << a[4:0];  // Shift amount comes in on a.
            mips_pkg::ALU_SRL:  y = b >> a[4:0];
            mips_pkg::ALU_SRA:  y = $signed(b) >>> a[4:0];
            mips_pkg::ALU_LUI:  y = {b[15:0], 16'd0};
            mips_pkg::ALU_OR:   y = a | b;
            mips_pkg::ALU_XOR:  y = a ^ b;
            mips_pkg::ALU_AND:  y = a & b;
            mips_pkg::ALU_NOR:  y = ~(a | b);
            default:            y = a + b;
        endcase
    end
endmodule

// File: hw/regfile.sv
`timescale 1ns/1ps
module regfile (
    input  logic        clk,
    input  logic [4:0]  rs_addr,
    input  logic [4:0]  rt_addr,
    input  logic        wen,
    input  logic [4:0]  waddr,
    input  logic [31:0] wdata,
    output logic [31:0] rs_data,
    output logic [31:0] rt_data
);
    logic [31:0] regs [32];

    always_ff @(posedge clk) begin
        if (wen && waddr != 5'd0) begin
            regs[waddr] <= wdata;
        end
    end

    assign rs_data = (rs_addr == 5'd0) ? 32'd0 : regs[rs_addr];  // r0 always reads zero.
    assign rt_data = (rt_addr == 5'd0) ? 32'd0 : regs[rt_addr];
endmodule

// File: hw/branch_ctrl.sv
`timescale 1ns/1ps
module branch_ctrl (
    input  logic              en,
    input  mips_pkg::opcode_e opcode,
    input  logic [4:0]        rt,
    input  logic [31:0]       rs_data,
    input  logic [31:0]       rt_data,
    output logic              take,
    output logic              link
);
    wire eq   = rs_data == rt_data;
    wire neg  = rs_data[31];
    wire zero = rs_data == 32'd0;

    always_comb begin
        take = 1'b0;
        if (en) begin
            case (opcode)
                mips_pkg::OP_BEQ:    take = eq;
                mips_pkg::OP_BNE:    take = ~eq;
                mips_pkg::OP_BLEZ:   take = neg | zero;
                mips_pkg::OP_BGTZ:   take = ~neg & ~zero;
                mips_pkg::OP_REGIMM: take = rt[0] ? ~neg : neg;  // Bit 0 picks bgez over bltz.
                default:             take = 1'b0;
            endcase
        end
    end

    assign link = en & (opcode == mips_pkg::OP_REGIMM) & rt[4];  // The al forms link always.
endmodule

// File: hw/control.sv
`timescale 1ns/1ps
module control (
    input  logic              valid,
    input  logic [31:0]       instr,
    input  logic [31:0]       rs_data,
    input  logic [31:0]       rt_data,
    output mips_pkg::ctrl_t   ctrl,
    output mips_pkg::pc_sel_e pc_sel
);
    mips_pkg::opcode_e opcode;
    mips_pkg::funct_e  funct;
    logic              take;
    logic              branch_link;

    assign opcode = mips_pkg::opcode_e'(instr[31:26]);
    assign funct  = mips_pkg::funct_e'(instr[5:0]);

    wire is_r    = opcode == mips_pkg::OP_SPECIAL;
    wire is_j    = opcode == mips_pkg::OP_J;
    wire is_jal  = opcode == mips_pkg::OP_JAL;
    wire is_sw   = opcode == mips_pkg::OP_SW;
    wire is_lb   = opcode == mips_pkg::OP_LB;
    wire is_lbu  = opcode == mips_pkg::OP_LBU;
    wire is_lh   = opcode == mips_pkg::OP_LH;
    wire is_lhu  = opcode == mips_pkg::OP_LHU;
    wire is_lw   = opcode == mips_pkg::OP_LW;
    wire is_addi = (opcode == mips_pkg::OP_ADDI) | (opcode == mips_pkg::OP_ADDIU);
    wire is_slti = opcode == mips_pkg::OP_SLTI;
    wire is_sltiu = opcode == mips_pkg::OP_SLTIU;
    wire is_andi = opcode == mips_pkg::OP_ANDI;
    wire is_ori  = opcode == mips_pkg::OP_ORI;
    wire is_xori = opcode == mips_pkg::OP_XORI;
    wire is_lui  = opcode == mips_pkg::OP_LUI;

    wire f_jr    = is_r & (funct == mips_pkg::F_JR);
    wire f_jalr  = is_r & (funct == mips_pkg::F_JALR);
    wire f_break = is_r & (funct == mips_pkg::F_BREAK);
    wire f_const = is_r & ((funct == mips_pkg::F_SLL) | (funct == mips_pkg::F_SRL) |
                           (funct == mips_pkg::F_SRA));

    wire is_load  = is_lb | is_lbu | is_lh | is_lhu | is_lw;
    wire imm_alu  = is_addi | is_slti | is_sltiu | is_andi | is_ori | is_xori | is_lui;
    wire link_31  = is_jal | branch_link;
    wire link     = link_31 | f_jalr;

    branch_ctrl u_branch_ctrl (
        .en      (valid),
        .opcode  (opcode),
        .rt      (instr[20:16]),
        .rs_data (rs_data),
        .rt_data (rt_data),
        .take    (take),
        .link    (branch_link)
    );

    always_comb begin
        ctrl.imm_sext    = ~(is_andi | is_ori | is_xori);
        ctrl.reg_write   = (is_r & ~f_jr & ~f_break) | imm_alu | is_load | link;
        ctrl.is_load     = is_load;
        ctrl.is_store    = is_sw;
        ctrl.load_signed = is_lb | is_lh;
        ctrl.halt        = f_break;

        ctrl.mem_size = mips_pkg::SZ_WORD;
        if (is_lb | is_lbu) ctrl.mem_size = mips_pkg::SZ_BYTE;
        else if (is_lh | is_lhu) ctrl.mem_size = mips_pkg::SZ_HALF;

        ctrl.waddr_sel = mips_pkg::W_RT;
        if (link_31) ctrl.waddr_sel = mips_pkg::W_R31;
        else if (is_r) ctrl.waddr_sel = mips_pkg::W_RD;

        ctrl.alu_a = mips_pkg::A_RS;
        if (link) ctrl.alu_a = mips_pkg::A_PC;  // Links compute pc + 8.
        else if (f_const) ctrl.alu_a = mips_pkg::A_SHAMT;

        ctrl.alu_b = mips_pkg::B_IMM;
        if (link) ctrl.alu_b = mips_pkg::B_EIGHT;
        else if (is_r) ctrl.alu_b = mips_pkg::B_RT;

        if (link) ctrl.alu_op = mips_pkg::ALU_ADD;
        else if (is_r & ((funct == mips_pkg::F_SUB) | (funct == mips_pkg::F_SUBU)))
            ctrl.alu_op = mips_pkg::ALU_SUB;
        else if (is_slti | (is_r & (funct == mips_pkg::F_SLT))) ctrl.alu_op = mips_pkg::ALU_SLT;
        else if (is_sltiu | (is_r & (funct == mips_pkg::F_SLTU)))
            ctrl.alu_op = mips_pkg::ALU_SLTU;
        else if (is_r & ((funct == mips_pkg::F_SLL) | (funct == mips_pkg::F_SLLV)))
            ctrl.alu_op = mips_pkg::ALU_SLL;
        else if (is_r & ((funct == mips_pkg::F_SRL) | (funct == mips_pkg::F_SRLV)))
            ctrl.alu_op = mips_pkg::ALU_SRL;
        else if (is_r & ((funct == mips_pkg::F_SRA) | (funct == mips_pkg::F_SRAV)))
            ctrl.alu_op = mips_pkg::ALU_SRA;
        else if (is_lui) ctrl.alu_op = mips_pkg::ALU_LUI;
        else if (is_ori | (is_r & (funct == mips_pkg::F_OR))) ctrl.alu_op = mips_pkg::ALU_OR;
        else if (is_xori | (is_r & (funct == mips_pkg::F_XOR))) ctrl.alu_op = mips_pkg::ALU_XOR;
        else if (is_andi | (is_r & (funct == mips_pkg::F_AND))) ctrl.alu_op = mips_pkg::ALU_AND;
        else if (is_r & (funct == mips_pkg::F_NOR)) ctrl.alu_op = mips_pkg::ALU_NOR;
        else ctrl.alu_op = mips_pkg::ALU_ADD;  // add, addu, addi, loads and sw.
    end

    always_comb begin
        pc_sel = mips_pkg::PC_NEXT;
        if (take) pc_sel = mips_pkg::PC_BRANCH;
        else if (valid & (is_j | is_jal)) pc_sel = mips_pkg::PC_JUMP;
        else if (valid & (f_jr | f_jalr)) pc_sel = mips_pkg::PC_REG;
    end
endmodule

// File: hw/fetch_unit.sv
`timescale 1ns/1ps
module fetch_unit (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               start,
    input  logic               advance,
    input  mips_pkg::pc_sel_e  pc_sel,
    input  logic [31:0]        rs_data,
    input  logic               mem_gnt,
    input  logic               mem_rvalid,
    input  logic [31:0]        mem_rdata,
    output mips_pkg::mem_req_t mem_req,
    output logic [31:0]        pc,
    output logic [31:0]        instr,
    output logic               instr_valid
);
    logic [31:0] pc_plus4;
    logic [31:0] next_pc;

    assign mem_req = '{valid: start, we: 1'b0, addr: pc[31:2], wdata: 32'd0, be: 4'hf};

    assign pc_plus4 = pc + 32'd4;

    always_comb begin
        case (pc_sel)
            mips_pkg::PC_BRANCH: next_pc = pc_plus4 + {{14{instr[15]}}, instr[15:0], 2'b00};
            mips_pkg::PC_JUMP:   next_pc = {pc_plus4[31:28], instr[25:0], 2'b00};
            mips_pkg::PC_REG:    next_pc = rs_data;
            default:             next_pc = pc_plus4;  // No delay slot.
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc          <= 32'd0;
            instr_valid <= 1'b0;
        end else begin
            if (advance) pc <= next_pc;
            if (start & mem_gnt) instr_valid <= 1'b0;
            else if (mem_rvalid) instr_valid <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (mem_rvalid) instr <= mem_rdata;
    end
endmodule

// File: hw/load_store_unit.sv
`timescale 1ns/1ps
module load_store_unit (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               start,
    input  mips_pkg::ctrl_t    ctrl,
    input  logic [31:0]        addr,
    input  logic [31:0]        store_data,
    input  logic               mem_gnt,
    input  logic               mem_rvalid,
    input  logic [31:0]        mem_rdata,
    output mips_pkg::mem_req_t mem_req,
    output logic               done,
    output logic [31:0]        load_data
);
    logic [1:0]  offset;
    logic        pending;
    logic [31:0] shifted;

    assign mem_req = '{valid: start, we: ctrl.is_store, addr: addr[31:2],
                       wdata: store_data, be: {4{ctrl.is_store}}};

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pending <= 1'b0;
        end else if (start & mem_gnt & ~ctrl.is_store) begin
            pending <= 1'b1;  // A read is now in flight.
        end else if (mem_rvalid) begin
            pending <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (start & mem_gnt) offset <= addr[1:0];
    end

    assign done = (start & mem_gnt & ctrl.is_store) | (pending & mem_rvalid);

    assign shifted = mem_rdata >> {offset, 3'b000};  // Little-endian lanes.

    always_comb begin
        case (ctrl.mem_size)
            mips_pkg::SZ_BYTE: load_data = {{24{ctrl.load_signed & shifted[7]}}, shifted[7:0]};
            mips_pkg::SZ_HALF: load_data = {{16{ctrl.load_signed & shifted[15]}}, shifted[15:0]};
            default:           load_data = mem_rdata;
        endcase
    end
endmodule

// File: hw/unified_mem.sv
`timescale 1ns/1ps
module unified_mem #(
    parameter int MEM_WORDS = 1024
) (
    input  logic               clk,
    input  logic               rst_n,
    input  mips_pkg::mem_req_t host_req,
    input  mips_pkg::mem_req_t lsu_req,
    input  mips_pkg::mem_req_t fetch_req,
    output logic               host_gnt,
    output logic               lsu_gnt,
    output logic               fetch_gnt,
    output logic [31:0]        rdata,
    output logic               host_rvalid,
    output logic               lsu_rvalid,
    output logic               fetch_rvalid
);
    localparam int AW = $clog2(MEM_WORDS);

    logic [31:0]        mem [MEM_WORDS];
    mips_pkg::mem_req_t sel;
    logic [AW-1:0]      idx;

    ////////////////////
    // Fixed priority arbiter
    ////////////////////
    assign host_gnt  = host_req.valid;
    assign lsu_gnt   = lsu_req.valid & ~host_req.valid;
    assign fetch_gnt = fetch_req.valid & ~host_req.valid & ~lsu_req.valid;

    always_comb begin
        if (host_req.valid) sel = host_req;
        else if (lsu_req.valid) sel = lsu_req;
        else sel = fetch_req;
    end

    assign idx = sel.addr[AW-1:0];  // Addresses wrap at the array depth.

    ////////////////////
    // Storage
    ////////////////////
    always_ff @(posedge clk) begin
        if (sel.valid & sel.we) begin
            for (int i = 0; i < 4; i++) begin
                if (sel.be[i]) mem[idx][8*i +: 8] <= sel.wdata[8*i +: 8];
            end
        end
        if (sel.valid & ~sel.we) rdata <= mem[idx];
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            host_rvalid  <= 1'b0;
            lsu_rvalid   <= 1'b0;
            fetch_rvalid <= 1'b0;
        end else begin
            host_rvalid  <= host_gnt & ~host_req.we;
            lsu_rvalid   <= lsu_gnt & ~lsu_req.we;
            fetch_rvalid <= fetch_gnt & ~fetch_req.we;
        end
    end
endmodule

// File: hw/mips_core.sv
`timescale 1ns/1ps
module mips_core #(
    parameter int MEM_WORDS = 1024
) (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               run,
    input  mips_pkg::mem_req_t host_req,
    output logic               host_gnt,
    output logic [31:0]        host_rdata,
    output logic               host_rvalid,
    output logic               retire_valid,
    output mips_pkg::retire_t  retire,
    output logic               halted
);
    typedef enum logic [2:0] {IDLE, FETCH, FWAIT, EXEC, MEM, MWAIT, HALT} state_e;

    state_e             state;
    mips_pkg::mem_req_t lsu_req, fetch_req;
    mips_pkg::ctrl_t    ctrl;
    mips_pkg::pc_sel_e  pc_sel;
    logic               lsu_gnt, fetch_gnt, lsu_rvalid, fetch_rvalid, instr_valid, lsu_done;
    logic [31:0]        pc, instr, mem_pc, rdata, rs_data, rt_data, imm, alu_a, alu_b, alu_y;
    logic [31:0]        load_data, wdata;
    logic [4:0]         waddr;
    logic               wen;

    wire in_exec = state == EXEC;
    wire is_mem  = ctrl.is_load | ctrl.is_store;

    ////////////////////
    // Sequencer
    ////////////////////
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= IDLE;
        end else begin
            case (state)
                IDLE:    if (run) state <= FETCH;
                FETCH:   if (fetch_gnt) state <= FWAIT;
                FWAIT:   if (fetch_rvalid) state <= EXEC;
                EXEC:    state <= ctrl.halt ? HALT : (is_mem ? MEM : FETCH);
                MEM: begin
                    if (lsu_done) state <= FETCH;  // A store retires on its grant.
                    else if (lsu_gnt) state <= MWAIT;
                end
                MWAIT:   if (lsu_done) state <= FETCH;
                default: state <= HALT;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (in_exec) mem_pc <= pc;  // pc moves on in EXEC.
    end

    fetch_unit u_fetch (
        .clk(clk), .rst_n(rst_n), .start(state == FETCH), .advance(in_exec),
        .pc_sel(pc_sel), .rs_data(rs_data), .mem_gnt(fetch_gnt), .mem_rvalid(fetch_rvalid),
        .mem_rdata(rdata), .mem_req(fetch_req), .pc(pc), .instr(instr),
        .instr_valid(instr_valid)
    );

    control u_control (
        .valid(instr_valid), .instr(instr), .rs_data(rs_data), .rt_data(rt_data),
        .ctrl(ctrl), .pc_sel(pc_sel)
    );

    regfile u_regfile (
        .clk(clk), .rs_addr(instr[25:21]), .rt_addr(instr[20:16]), .wen(wen),
        .waddr(waddr), .wdata(wdata), .rs_data(rs_data), .rt_data(rt_data)
    );

    ////////////////////
    // Operands and writeback
    ////////////////////
    assign imm = ctrl.imm_sext ? {{16{instr[15]}}, instr[15:0]} : {16'd0, instr[15:0]};

    assign alu_a = (ctrl.alu_a == mips_pkg::A_PC) ? pc :
                   (ctrl.alu_a == mips_pkg::A_SHAMT) ? {27'd0, instr[10:6]} : rs_data;
    assign alu_b = (ctrl.alu_b == mips_pkg::B_EIGHT) ? 32'd8 :
                   (ctrl.alu_b == mips_pkg::B_IMM) ? imm : rt_data;

    alu u_alu (.op(ctrl.alu_op), .a(alu_a), .b(alu_b), .y(alu_y));

    load_store_unit u_lsu (
        .clk(clk), .rst_n(rst_n), .start(state == MEM), .ctrl(ctrl), .addr(alu_y),
        .store_data(rt_data), .mem_gnt(lsu_gnt), .mem_rvalid(lsu_rvalid), .mem_rdata(rdata),
        .mem_req(lsu_req), .done(lsu_done), .load_data(load_data)
    );

    unified_mem #(.MEM_WORDS(MEM_WORDS)) u_mem (
        .clk(clk), .rst_n(rst_n), .host_req(host_req), .lsu_req(lsu_req),
        .fetch_req(fetch_req), .host_gnt(host_gnt), .lsu_gnt(lsu_gnt), .fetch_gnt(fetch_gnt),
        .rdata(rdata), .host_rvalid(host_rvalid), .lsu_rvalid(lsu_rvalid),
        .fetch_rvalid(fetch_rvalid)
    );

    assign waddr = (ctrl.waddr_sel == mips_pkg::W_R31) ? 5'd31 :
                   (ctrl.waddr_sel == mips_pkg::W_RD) ? instr[15:11] : instr[20:16];
    assign wdata = ctrl.is_load ? load_data : alu_y;
    assign wen   = (in_exec & ctrl.reg_write & ~is_mem & ~ctrl.halt) | (lsu_done & ctrl.is_load);

    assign retire_valid = (in_exec & ~is_mem & ~ctrl.halt) | lsu_done;
    assign retire       = '{pc: in_exec ? pc : mem_pc, wen: wen, waddr: waddr, wdata: wdata};
    assign host_rdata   = rdata;
    assign halted       = state == HALT;
endmodule

// File: bench/mips_core_assert.sv
`timescale 1ns/1ps
module mips_core_assert (
    input logic               clk,
    input logic               rst_n,
    input logic               host_gnt,
    input logic               lsu_gnt,
    input logic               fetch_gnt,
    input mips_pkg::mem_req_t lsu_req,
    input mips_pkg::mem_req_t fetch_req,
    input logic               retire_valid,
    input logic               halted
);
    one_grant: assert property (@(posedge clk) disable iff (!rst_n)
        $onehot0({host_gnt, lsu_gnt, fetch_gnt}))
        else $error("More than one requester granted in a cycle.");

    lsu_hold: assert property (@(posedge clk) disable iff (!rst_n)
        lsu_req.valid && !lsu_gnt |=> lsu_req == $past(lsu_req))
        else $error("Refused load/store request changed before its grant.");

    fetch_hold: assert property (@(posedge clk) disable iff (!rst_n)
        fetch_req.valid && !fetch_gnt |=> fetch_req == $past(fetch_req))
        else $error("Refused fetch request changed before its grant.");

    retire_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        retire_valid |=> !retire_valid)
        else $error("retire_valid stayed high for more than one cycle.");

    halt_quiet: assert property (@(posedge clk) disable iff (!rst_n)
        !(halted && retire_valid))
        else $error("Retire seen while the core is halted.");
endmodule

bind mips_core mips_core_assert u_assert (.*);

// File: bench/tb_mips_core.sv
`timescale 1ns/1ps
module tb_mips_core;
    localparam logic [31:0] SCRATCH_ADDR = 32'h0000_03f0;
    localparam logic [31:0] SCRATCH_DATA = 32'h5ca7_c0de;
    localparam int          TIMEOUT      = 2000;

    logic               clk = 1'b0;
    logic               rst_n;
    logic               run;
    mips_pkg::mem_req_t host_req;
    logic               host_gnt;
    logic [31:0]        host_rdata;
    logic               host_rvalid;
    logic               retire_valid;
    mips_pkg::retire_t  retire;
    logic               halted;

    logic [8*24-1:0]    test_name = "setup";
    logic [31:0]        prog_addr[$];
    logic [31:0]        prog_word[$];
    logic [31:0]        mem_addr[$];
    logic [31:0]        mem_word[$];
    mips_pkg::retire_t  exp_ret[$];
    logic [31:0]        rng = 32'd35;

    mips_core UUT (
        .clk(clk), .rst_n(rst_n), .run(run), .host_req(host_req), .host_gnt(host_gnt),
        .host_rdata(host_rdata), .host_rvalid(host_rvalid), .retire_valid(retire_valid),
        .retire(retire), .halted(halted)
    );

    always #4 clk = ~clk;

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] s;
        s = x ^ (x << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    task automatic check(input logic [8*24-1:0] what, input logic [31:0] expected,
                         input logic [31:0] actual);
        if (expected !== actual) begin
            $display("Error: test %0s, %0s, expected %h, actual %h",
                     test_name, what, expected, actual);
            $display("CHECKS FAILED");
            $fatal(1);
        end
    endtask

    task automatic fail(input logic [8*48-1:0] what);
        $display("Test %0s went wrong: %0s", test_name, what);
        $display("CHECKS FAILED");
        $fatal(1);
    endtask

    task automatic drive_host(input logic we, input logic [31:0] addr, input logic [31:0] data);
        host_req = '{valid: 1'b1, we: we, addr: addr[31:2], wdata: data, be: 4'hf};
    endtask

    // Called 1 ns after the falling edge on which the request went out.
    task automatic wait_grant();
        int n;
        n = 0;
        while (!host_gnt) begin
            n++;
            if (n > TIMEOUT) fail("no host grant");
            @(negedge clk);
            #1;
        end
    endtask

    task automatic host_write(input logic [31:0] addr, input logic [31:0] data);
        @(negedge clk);
        drive_host(1'b1, addr, data);
        #1;
        wait_grant();
    endtask

    task automatic host_read(input logic [31:0] addr, output logic [31:0] data);
        int n;
        @(negedge clk);
        drive_host(1'b0, addr, 32'd0);
        #1;
        wait_grant();
        @(negedge clk);
        host_req = '0;
        #1;
        n = 0;
        while (!host_rvalid) begin
            n++;
            if (n > TIMEOUT) fail("no host read data");
            @(negedge clk);
            #1;
        end
        data = host_rdata;
    endtask

    task automatic run_case();
        int          n;
        int          idx;
        logic        pend;
        logic        issued;
        logic [31:0] rd;
        rst_n    = 1'b0;
        run      = 1'b0;
        host_req = '0;
        repeat (10) @(negedge clk);
        rst_n = 1'b1;
        #1;
        check("halted after reset", 32'd0, {31'd0, halted});
        host_write(SCRATCH_ADDR, SCRATCH_DATA);
        foreach (prog_addr[i]) host_write(prog_addr[i], prog_word[i]);
        @(negedge clk);
        host_req = '0;
        run      = 1'b1;

        ////////////////////
        // Run with random host reads of the scratch word
        ////////////////////
        idx  = 0;
        pend = 1'b0;
        n    = 0;
        while (!halted || pend) begin
            @(negedge clk);
            issued   = 1'b0;
            host_req = '0;
            rng      = xorshift(rng);
            if (!pend && !halted && rng[1:0] == 2'd0) begin
                drive_host(1'b0, SCRATCH_ADDR, 32'd0);
                issued = 1'b1;
            end
            #1;
            // The host port has top priority, so its read is granted at once.
            check("host_gnt", {31'd0, issued}, {31'd0, host_gnt});
            check("host_rvalid", {31'd0, pend}, {31'd0, host_rvalid});
            if (pend) begin
                check("scratch word", SCRATCH_DATA, host_rdata);
            end
            pend = issued;
            if (retire_valid) begin
                if (idx >= exp_ret.size()) fail("more retirements than expected");
                check("retire pc", exp_ret[idx].pc, retire.pc);
                check("retire wen", {31'd0, exp_ret[idx].wen}, {31'd0, retire.wen});
                if (exp_ret[idx].wen) begin
                    check("retire reg", {27'd0, exp_ret[idx].waddr}, {27'd0, retire.waddr});
                    check("retire data", exp_ret[idx].wdata, retire.wdata);
                end
                idx++;
            end
            n++;
            if (n > TIMEOUT) fail("core never halted");
        end
        check("retire count", exp_ret.size(), idx);

        // halted holds and nothing retires after break.
        repeat (4) begin
            @(negedge clk);
            #1;
            check("halted level", 32'd1, {31'd0, halted});
            check("retire after halt", 32'd0, {31'd0, retire_valid});
        end

        foreach (mem_addr[i]) begin
            host_read(mem_addr[i], rd);
            check("memory word", mem_word[i], rd);
        end
        @(negedge clk);
        host_req = '0;
    endtask

    initial begin
        int                fd;
        int                code;
        logic [8*16-1:0]   kind;
        logic [8*128-1:0]  line;
        logic [31:0]       a;
        logic [31:0]       w;
        logic [31:0]       wen;
        logic [31:0]       wreg;
        logic [31:0]       data;
        rst_n    = 1'b0;
        run      = 1'b0;
        host_req = '0;
        fd = $fopen("bench/program_cases.txt", "r");
        if (fd == 0) fail("cannot open bench/program_cases.txt");
        while ($fscanf(fd, " %s", kind) == 1) begin
            if (kind == "#") begin
                code = $fgets(line, fd);
            end else if (kind == "T") begin
                code = $fscanf(fd, " %s", test_name);
                if (code != 1) fail("malformed test name line");
            end else if (kind == "P") begin
                code = $fscanf(fd, " %h %h", a, w);
                if (code != 2) fail("malformed program line");
                prog_addr.push_back(a);
                prog_word.push_back(w);
            end else if (kind == "I") begin
                code = $fscanf(fd, " %h %h %h %h %h", a, w, wen, wreg, data);
                if (code != 5) fail("malformed retire line");
                prog_addr.push_back(a);
                prog_word.push_back(w);
                exp_ret.push_back('{pc: a, wen: wen[0], waddr: wreg[4:0], wdata: data});
            end else if (kind == "M") begin
                code = $fscanf(fd, " %h %h", a, w);
                if (code != 2) fail("malformed memory line");
                mem_addr.push_back(a);
                mem_word.push_back(w);
            end else if (kind == "E") begin
                run_case();
                prog_addr.delete();
                prog_word.delete();
                mem_addr.delete();
                mem_word.delete();
                exp_ret.delete();
            end else begin
                fail("unknown line kind in the cases file");
            end
        end
        $fclose(fd);
        $display("ALL CHECKS PASSED");
        $finish;
    end
endmodule

// File: mips_core.f
hw/mips_pkg.sv
hw/alu.sv
hw/regfile.sv
hw/branch_ctrl.sv
hw/control.sv
hw/fetch_unit.sv
hw/load_store_unit.sv
hw/unified_mem.sv
hw/mips_core.sv
bench/mips_core_assert.sv
bench/tb_mips_core.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_mips_core -f mips_core.f -o sim_mips_core

out=$(./obj_dir/sim_mips_core) || true
echo "$out"
echo "$out" | grep -q "ALL CHECKS PASSED"

// File: bench/program_cases.txt
# T name | P addr word (never retires) | I addr word wen reg data (retires, in order)
# M addr word (final memory) | E runs the case
T alu
I 00 24010007 1 01 00000007
I 04 3c028000 1 02 80000000
I 08 00021903 1 03 f8000000
I 0c 00022102 1 04 08000000
I 10 0061282a 1 05 00000001
I 14 0061302b 1 06 00000000
I 18 00203827 1 07 fffffff8
I 1c 20000005 1 00 00000005
I 20 00014023 1 08 fffffff9
I 24 38e9ffff 1 09 ffff0007
I 28 00215004 1 0a 00000380
P 2c 0000000d
E
T branch
I 00 2401ffff 1 01 ffffffff
I 04 24020001 1 02 00000001
I 08 10220001 0 00 00000000
I 0c 14220001 0 00 00000000
I 14 04200001 0 00 00000000
I 1c 04210001 0 00 00000000
I 20 04500001 1 1f 00000028
I 24 04510001 1 1f 0000002c
I 2c 18200001 0 00 00000000
I 34 1c400001 0 00 00000000
I 3c 0c000014 1 1f 00000044
I 50 03e02809 1 05 00000058
I 44 08000018 0 00 00000000
I 60 24060070 1 06 00000070
I 64 00c00008 0 00 00000000
P 10 0000000d
P 18 0000000d
P 28 0000000d
P 30 0000000d
P 38 0000000d
P 48 0000000d
P 68 0000000d
P 70 0000000d
E
T memory
I 00 3c018081 1 01 80810000
I 04 342182ff 1 01 808182ff
I 08 ac010100 0 00 00000000
I 0c 80020100 1 02 ffffffff
I 10 90030101 1 03 00000082
I 14 80040102 1 04 ffffff81
I 18 90050103 1 05 00000080
I 1c 84060100 1 06 ffff82ff
I 20 94070102 1 07 00008081
I 24 8c080100 1 08 808182ff
I 28 ac080104 0 00 00000000
I 2c 84090102 1 09 ffff8081
I 30 800a0101 1 0a ffffff82
I 34 900b0100 1 0b 000000ff
I 38 800c0103 1 0c ffffff80
I 3c 940d0100 1 0d 000082ff
I 40 900e0102 1 0e 00000081
P 44 0000000d
M 100 808182ff
M 104 808182ff
E
